// File: design/rv32i_types.sv
package rv32i_types;

	// ------------------------------------------------------------
	// basic data types
	// ------------------------------------------------------------

	// one 32-bit word, used for addresses and data alike.
	typedef logic [31:0] rv32i_word;

	// a full cache line of 32 bytes.
	typedef logic [255:0] cache_line_t;

	// ------------------------------------------------------------
	// cache geometry
	// ------------------------------------------------------------

	localparam int num_sets    = 8;
	localparam int offset_bits = 5;
	localparam int index_bits  = 3;
	localparam int tag_bits    = 24;

	// ------------------------------------------------------------
	// physical memory port
	// ------------------------------------------------------------

	// a line-sized request, held unchanged until resp is seen.
	typedef struct packed {
		logic        read;
		logic        write;
		rv32i_word   address;
		cache_line_t wdata;
	} pmem_req_t;

	// resp is a single-cycle pulse and rdata is valid with it.
	typedef struct packed {
		logic        resp;
		cache_line_t rdata;
	} pmem_rsp_t;

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------

	// shared by both caches; the icache never writes back.
	typedef enum logic [1:0] {
		st_check,
		st_writeback,
		st_fill
	} cache_state_t;

	typedef enum logic [1:0] {
		arb_idle,
		arb_icache,
		arb_dcache
	} arb_state_t;

endpackage : rv32i_types

// File: design/icache.sv
`timescale 1ns/1ps

module icache import rv32i_types::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      iread,
	input  rv32i_word inst_addr,
	input  pmem_rsp_t irsp,
	output rv32i_word inst,
	output logic      iready,
	output pmem_req_t ireq
);

	// address fields of the current fetch.
	logic [tag_bits-1:0]      addr_tag;
	logic [index_bits-1:0]    addr_index;
	logic [offset_bits-3:0]   addr_word;

	// the arrays are flip-flops, so every read below is combinational.
	logic                     valid [num_sets];
	logic [tag_bits-1:0]      tags  [num_sets];
	cache_line_t              lines [num_sets];

	cache_state_t             state;
	logic                     hit;
	logic                     fill_done;

	assign addr_tag   = inst_addr[offset_bits + index_bits +: tag_bits];
	assign addr_index = inst_addr[offset_bits +: index_bits];
	assign addr_word  = inst_addr[offset_bits-1:2];

	assign hit       = valid[addr_index] && (tags[addr_index] == addr_tag);
	assign fill_done = (state == st_fill) && irsp.resp;

	// ------------------------------------------------------------
	// core side
	// ------------------------------------------------------------

	// with no fetch pending the cache reports ready so the data side can advance.
	assign iready = !iread || ((state == st_check) && hit);
	assign inst   = lines[addr_index][32*addr_word +: 32];

	// ------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------

	// the core holds inst_addr during a miss, so the request stays stable.
	always_comb begin
		ireq         = '0;
		ireq.read    = (state == st_fill);
		ireq.address = {inst_addr[31:offset_bits], {offset_bits{1'b0}}};
	end

	// control state and valid bits.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_check;
			for (int i = 0; i < num_sets; i++) begin
				valid[i] <= 1'b0;
			end
		end else begin
			case (state)
				st_check: begin
					// a miss spends this one cycle here before the fill starts.
					if (iread && !hit) begin
						state <= st_fill;
					end
				end
				st_fill: begin
					if (irsp.resp) begin
						state             <= st_check;
						valid[addr_index] <= 1'b1;
					end
				end
				default: begin
					state <= st_check;
				end
			endcase
		end
	end

	// line data and tags are written only when a fill completes.
	always_ff @(posedge clk) begin
		if (fill_done) begin
			lines[addr_index] <= irsp.rdata;
			tags[addr_index]  <= addr_tag;
		end
	end

endmodule : icache

// File: design/dcache.sv
`timescale 1ns/1ps

module dcache import rv32i_types::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       dread,
	input  logic       dwrite,
	input  rv32i_word  mem_address,
	input  rv32i_word  mem_wdata,
	input  logic [3:0] mem_byte_enable,
	input  logic       load_pipeline,
	input  pmem_rsp_t  drsp,
	output rv32i_word  mem_rdata,
	output logic       dready,
	output pmem_req_t  dreq
);

	// address fields of the current access.
	logic [tag_bits-1:0]      addr_tag;
	logic [index_bits-1:0]    addr_index;
	logic [offset_bits-3:0]   addr_word;

	// flip-flop arrays, read combinationally.
	logic                     valid [num_sets];
	logic                     dirty [num_sets];
	logic [tag_bits-1:0]      tags  [num_sets];
	cache_line_t              lines [num_sets];

	cache_state_t             state;
	logic                     access;
	logic                     hit;
	logic                     write_hit;
	logic                     fill_done;
	logic                     victim_dirty;
	rv32i_word                wb_address;
	rv32i_word                fill_address;
	cache_line_t              merged_line;

	assign addr_tag   = mem_address[offset_bits + index_bits +: tag_bits];
	assign addr_index = mem_address[offset_bits +: index_bits];
	assign addr_word  = mem_address[offset_bits-1:2];

	assign access       = dread || dwrite;
	assign hit          = valid[addr_index] && (tags[addr_index] == addr_tag);
	assign victim_dirty = valid[addr_index] && dirty[addr_index];
	assign fill_done    = (state == st_fill) && drsp.resp;

	// a write lands only on the edge where the whole pipeline moves,
	// otherwise an icache stall would let it commit twice.
	assign write_hit = (state == st_check) && hit && dwrite && load_pipeline;

	// the victim goes back to the address it came from.
	assign wb_address   = {tags[addr_index], addr_index, {offset_bits{1'b0}}};
	assign fill_address = {mem_address[31:offset_bits], {offset_bits{1'b0}}};

	// ------------------------------------------------------------
	// core side
	// ------------------------------------------------------------

	assign dready    = !access || ((state == st_check) && hit);
	assign mem_rdata = lines[addr_index][32*addr_word +: 32];

	// the addressed word with only its enabled bytes replaced.
	always_comb begin
		merged_line = lines[addr_index];
		for (int i = 0; i < 4; i++) begin
			if (mem_byte_enable[i]) begin
				merged_line[32*addr_word + 8*i +: 8] = mem_wdata[8*i +: 8];
			end
		end
	end

	// ------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------

	always_comb begin
		dreq = '0;
		if (state == st_writeback) begin
			dreq.write   = 1'b1;
			dreq.address = wb_address;
			dreq.wdata   = lines[addr_index];
		end else if (state == st_fill) begin
			dreq.read    = 1'b1;
			dreq.address = fill_address;
		end
	end

	// control state, valid and dirty bits.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_check;
			for (int i = 0; i < num_sets; i++) begin
				valid[i] <= 1'b0;
				dirty[i] <= 1'b0;
			end
		end else begin
			case (state)
				st_check: begin
					if (access && !hit) begin
						// a dirty victim must reach memory before it is overwritten.
						state <= victim_dirty ? st_writeback : st_fill;
					end else if (write_hit) begin
						dirty[addr_index] <= 1'b1;
					end
				end
				st_writeback: begin
					if (drsp.resp) begin
						state <= st_fill;
					end
				end
				st_fill: begin
					if (drsp.resp) begin
						state             <= st_check;
						valid[addr_index] <= 1'b1;
						dirty[addr_index] <= 1'b0;
					end
				end
				default: begin
					state <= st_check;
				end
			endcase
		end
	end

	// line data and tags, written on a fill or a committed write hit.
	always_ff @(posedge clk) begin
		if (fill_done) begin
			lines[addr_index] <= drsp.rdata;
			tags[addr_index]  <= addr_tag;
		end else if (write_hit) begin
			lines[addr_index] <= merged_line;
		end
	end

endmodule : dcache

// File: design/arbiter.sv
`timescale 1ns/1ps

module arbiter import rv32i_types::*; (
	input  logic      clk,
	input  logic      rst,
	input  pmem_req_t ireq,
	input  pmem_req_t dreq,
	input  pmem_rsp_t pmem_rsp,
	output pmem_rsp_t irsp,
	output pmem_rsp_t drsp,
	output pmem_req_t pmem_req
);

	arb_state_t state;
	logic       ireq_pending;
	logic       dreq_pending;

	assign ireq_pending = ireq.read || ireq.write;
	assign dreq_pending = dreq.read || dreq.write;

	// ------------------------------------------------------------
	// grant register
	// ------------------------------------------------------------

	// the data side wins a tie. the grant drops on the resp edge, which
	// leaves one idle cycle before the next grant.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= arb_idle;
		end else begin
			case (state)
				arb_idle: begin
					if (dreq_pending) begin
						state <= arb_dcache;
					end else if (ireq_pending) begin
						state <= arb_icache;
					end
				end
				arb_icache, arb_dcache: begin
					if (pmem_rsp.resp) begin
						state <= arb_idle;
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// request and response routing
	// ------------------------------------------------------------

	// nothing reaches memory while idle.
	always_comb begin
		case (state)
			arb_icache: pmem_req = ireq;
			arb_dcache: pmem_req = dreq;
			default:    pmem_req = '0;
		endcase
	end

	// rdata is shared, only resp is steered.
	always_comb begin
		irsp.rdata = pmem_rsp.rdata;
		drsp.rdata = pmem_rsp.rdata;
		irsp.resp  = pmem_rsp.resp && (state == arb_icache);
		drsp.resp  = pmem_rsp.resp && (state == arb_dcache);
	end

endmodule : arbiter

// File: design/mem_hier.sv
`timescale 1ns/1ps

module mem_hier import rv32i_types::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       iread,
	input  rv32i_word  inst_addr,
	input  logic       dread,
	input  logic       dwrite,
	input  rv32i_word  mem_address,
	input  rv32i_word  mem_wdata,
	input  logic [3:0] mem_byte_enable,
	input  pmem_rsp_t  pmem_rsp,
	output rv32i_word  inst,
	output rv32i_word  mem_rdata,
	output logic       load_pipeline,
	output pmem_req_t  pmem_req
);

	logic      iready;
	logic      dready;
	pmem_req_t ireq;
	pmem_req_t dreq;
	pmem_rsp_t irsp;
	pmem_rsp_t drsp;

	// the core advances only when both sides can finish this cycle.
	assign load_pipeline = iready && dready;

	icache icache (
		.clk       (clk),
		.rst       (rst),
		.iread     (iread),
		.inst_addr (inst_addr),
		.irsp      (irsp),
		.inst      (inst),
		.iready    (iready),
		.ireq      (ireq)
	);

	dcache dcache (
		.clk             (clk),
		.rst             (rst),
		.dread           (dread),
		.dwrite          (dwrite),
		.mem_address     (mem_address),
		.mem_wdata       (mem_wdata),
		.mem_byte_enable (mem_byte_enable),
		.load_pipeline   (load_pipeline),
		.drsp            (drsp),
		.mem_rdata       (mem_rdata),
		.dready          (dready),
		.dreq            (dreq)
	);

	arbiter arbiter (
		.clk      (clk),
		.rst      (rst),
		.ireq     (ireq),
		.dreq     (dreq),
		.pmem_rsp (pmem_rsp),
		.irsp     (irsp),
		.drsp     (drsp),
		.pmem_req (pmem_req)
	);

endmodule : mem_hier

// File: sim/mem_hier_chk.sv
`timescale 1ns/1ps

module mem_hier_chk import rv32i_types::*; (
	input logic       clk,
	input logic       rst,
	input arb_state_t state,
	input pmem_req_t  pmem_req,
	input pmem_rsp_t  pmem_rsp
);

	// number of failed assertions, read by the testbench at the end of the run.
	int failures = 0;

	// ------------------------------------------------------------
	// memory port rules
	// ------------------------------------------------------------

	// a line transfer is either a read or a write, never both.
	read_write_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(pmem_req.read && pmem_req.write)
	) else begin
		$error("memory request has read and write high together");
		failures++;
	end

	// the granted cache holds its request until memory answers.
	request_stable: assert property (
		@(posedge clk) disable iff (rst)
		(state != arb_idle && !pmem_rsp.resp) |=> $stable(pmem_req)
	) else begin
		$error("granted memory request changed before resp");
		failures++;
	end

	// ------------------------------------------------------------
	// arbiter rules
	// ------------------------------------------------------------

	// the grant drops right after resp, which leaves one idle cycle.
	idle_after_resp: assert property (
		@(posedge clk) disable iff (rst)
		(state != arb_idle && pmem_rsp.resp) |=> (state == arb_idle)
	) else begin
		$error("arbiter kept the grant after resp");
		failures++;
	end

endmodule : mem_hier_chk

// File: sim/mem_hier_tb.sv
`timescale 1ns/1ps

module mem_hier_tb import rv32i_types::*; ();

	localparam rv32i_word inst_base  = 32'h0001_0000;
	localparam rv32i_word data_base  = 32'h0000_2000;
	localparam rv32i_word flush_base = 32'h0000_4000;
	localparam int        max_wait   = 200;

	logic       clk = 1'b0;
	logic       rst;
	logic       iread;
	rv32i_word  inst_addr;
	logic       dread;
	logic       dwrite;
	rv32i_word  mem_address;
	rv32i_word  mem_wdata;
	logic [3:0] mem_byte_enable;
	pmem_rsp_t  pmem_rsp;
	rv32i_word  inst;
	rv32i_word  mem_rdata;
	logic       load_pipeline;
	pmem_req_t  pmem_req;

	// physical memory by line address, and the core's view by word address.
	cache_line_t mem [rv32i_word];
	rv32i_word   ref_words [rv32i_word];

	logic        mem_busy;
	int unsigned mem_wait;
	int          errors = 0;
	int          timeouts = 0;
	rv32i_word   addr;

	mem_hier dut (.*);

	bind arbiter mem_hier_chk chk (
		.clk      (clk),
		.rst      (rst),
		.state    (state),
		.pmem_req (pmem_req),
		.pmem_rsp (pmem_rsp)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------
	// memory and reference model
	// ------------------------------------------------------------

	function automatic rv32i_word line_of(input rv32i_word a);
		return {a[31:offset_bits], {offset_bits{1'b0}}};
	endfunction

	// a line gets random contents the first time anyone touches it.
	function automatic void ensure_line(input rv32i_word line_addr);
		cache_line_t fresh;
		if (!mem.exists(line_addr)) begin
			for (int w = 0; w < 8; w++) begin
				fresh[32*w +: 32] = $urandom;
				ref_words[rv32i_word'(line_addr + 4*w)] = fresh[32*w +: 32];
			end
			mem[line_addr] = fresh;
		end
	endfunction

	function automatic rv32i_word ref_read(input rv32i_word a);
		ensure_line(line_of(a));
		return ref_words[a];
	endfunction

	function automatic rv32i_word mem_word(input rv32i_word a);
		ensure_line(line_of(a));
		return mem[line_of(a)][32*a[offset_bits-1:2] +: 32];
	endfunction

	function automatic void apply_write(input rv32i_word a, input rv32i_word wdata,
			input logic [3:0] be);
		rv32i_word w;
		w = ref_read(a);
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				w[8*i +: 8] = wdata[8*i +: 8];
			end
		end
		ref_words[a] = w;
	endfunction

	// a random word address in a region of 32 lines.
	function automatic rv32i_word rand_addr(input rv32i_word base);
		return base + ($urandom_range(0, 255) << 2);
	endfunction

	// memory answers each request after 1 to 6 cycles with one resp pulse.
	always @(posedge clk) begin
		if (rst) begin
			pmem_rsp <= '0;
			mem_busy = 1'b0;
		end else if (pmem_rsp.resp) begin
			pmem_rsp.resp <= 1'b0;
		end else if (mem_busy) begin
			mem_wait--;
			if (mem_wait == 0) begin
				ensure_line(pmem_req.address);
				if (pmem_req.write) begin
					mem[pmem_req.address] = pmem_req.wdata;
				end else begin
					pmem_rsp.rdata <= mem[pmem_req.address];
				end
				pmem_rsp.resp <= 1'b1;
				mem_busy = 1'b0;
			end
		end else if (pmem_req.read || pmem_req.write) begin
			mem_busy = 1'b1;
			mem_wait = $urandom_range(1, 6);
		end
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input rv32i_word exp, input rv32i_word act);
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_line(input string name, input cache_line_t exp, input cache_line_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// ------------------------------------------------------------
	// core side
	// ------------------------------------------------------------

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_bit("pmem_req.read", 1'b0, pmem_req.read);
			check_bit("pmem_req.write", 1'b0, pmem_req.write);
			check_bit("load_pipeline", 1'b1, load_pipeline);
		end
	endtask

	// one core cycle's worth of requests, held until load_pipeline is high.
	task automatic do_txn(input logic fetch, input rv32i_word iaddr, input logic rd,
			input logic wr, input rv32i_word daddr, input rv32i_word wdata,
			input logic [3:0] be);
		int waited;
		if (timeouts == 0) begin
			@(posedge clk);
			iread           <= fetch;
			inst_addr       <= iaddr;
			dread           <= rd;
			dwrite          <= wr;
			mem_address     <= daddr;
			mem_wdata       <= wdata;
			mem_byte_enable <= be;
			waited = 0;
			@(negedge clk);
			while (!load_pipeline && waited < max_wait) begin
				@(negedge clk);
				waited++;
			end
			if (!load_pipeline) begin
				timeouts++;
				$display("timeout: load_pipeline stayed low for %0d cycles, fetch %h, data %h",
					max_wait, iaddr, daddr);
			end else begin
				if (fetch) begin
					check_word("inst", mem_word(iaddr), inst);
				end
				if (rd) begin
					check_word("mem_rdata", ref_read(daddr), mem_rdata);
				end
				// the write lands on the coming edge.
				if (wr) begin
					apply_write(daddr, wdata, be);
				end
			end
		end
	endtask

	task automatic random_txn();
		int op;
		op = $urandom_range(0, 2);
		do_txn($urandom_range(0, 3) != 0, rand_addr(inst_base), op == 1, op == 2,
			rand_addr(data_base), $urandom, 4'($urandom));
	endtask

	task automatic check_memory();
		cache_line_t exp_line;
		foreach (mem[a]) begin
			for (int w = 0; w < 8; w++) begin
				exp_line[32*w +: 32] = ref_words[rv32i_word'(a + 4*w)];
			end
			check_line($sformatf("mem[%h]", a), exp_line, mem[a]);
		end
	endtask

	initial begin
		void'($urandom(49510));
		rst             = 1'b1;
		iread           = 1'b0;
		inst_addr       = '0;
		dread           = 1'b0;
		dwrite          = 1'b0;
		mem_address     = '0;
		mem_wdata       = '0;
		mem_byte_enable = '0;
		pmem_rsp        = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		check_idle(5);

		// fetch and data miss together, then hit the same lines again.
		do_txn(1'b1, inst_base, 1'b1, 1'b0, data_base, '0, '0);
		do_txn(1'b1, inst_base + 4, 1'b1, 1'b0, data_base + 8, '0, '0);

		// byte-enable write followed by a read of the same word.
		addr = rand_addr(data_base);
		do_txn(1'b0, '0, 1'b0, 1'b1, addr, $urandom, 4'($urandom));
		do_txn(1'b0, '0, 1'b1, 1'b0, addr, '0, '0);

		// same index, other tag, so the dirty line is written back.
		do_txn(1'b0, '0, 1'b1, 1'b0, addr ^ 32'h100, '0, '0);
		do_txn(1'b0, '0, 1'b1, 1'b0, addr, '0, '0);

		for (int n = 0; n < 400; n++) begin
			random_txn();
		end

		// one read per set from an unused region pushes every dirty line out.
		for (int s = 0; s < num_sets; s++) begin
			do_txn(1'b0, '0, 1'b1, 1'b0, flush_base + 32*s, '0, '0);
		end
		@(posedge clk);
		iread  <= 1'b0;
		dread  <= 1'b0;
		dwrite <= 1'b0;
		if (timeouts == 0) begin
			check_idle(3);
			check_memory();
		end

		$display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
			errors, dut.arbiter.chk.failures, timeouts);
		if (errors == 0 && dut.arbiter.chk.failures == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule : mem_hier_tb

// File: all.f
design/rv32i_types.sv
design/icache.sv
design/dcache.sv
design/arbiter.sv
design/mem_hier.sv
sim/mem_hier_chk.sv
sim/mem_hier_tb.sv
